// ==== src/rob_pkg.sv ====
package rob_pkg;

    // buffer geometry
    localparam int rob_size    = 16;
    localparam int width       = 2;      // dispatch and commit slots per cycle
    localparam int fu_ports    = 3;      // completion ports from the FUs
    localparam int alert_depth = width;  // free slots held back for almost_full

    // pointer and counter widths
    localparam int ptr_width   = 4;      // indexes rob_size entries
    localparam int cnt_width   = 5;      // counts 0 to rob_size inclusive

    // rob entry number that wraps modulo rob_size
    typedef logic [ptr_width-1:0] robn_t;

    // occupancy of the buffer
    typedef logic [cnt_width-1:0] rob_cnt_t;

    // architectural register number
    typedef logic [4:0] arn_t;

    // physical register number
    typedef logic [5:0] prn_t;

    // instruction address
    typedef logic [31:0] addr_t;

endpackage

// ==== src/rob_entry_array.sv ====
`timescale 1ns/1ns

module rob_entry_array (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic [rob_pkg::width-1:0]                alloc_en,
    input  rob_pkg::robn_t [rob_pkg::width-1:0]      alloc_robn,
    input  logic [rob_pkg::width-1:0]                dispatch_is_branch,
    input  logic [rob_pkg::width-1:0]                dispatch_predict_taken,
    input  rob_pkg::addr_t [rob_pkg::width-1:0]      dispatch_predict_target,
    input  rob_pkg::addr_t [rob_pkg::width-1:0]      dispatch_npc,
    input  rob_pkg::arn_t [rob_pkg::width-1:0]       dispatch_dest_arn,
    input  rob_pkg::prn_t [rob_pkg::width-1:0]       dispatch_dest_prn,
    input  logic [rob_pkg::fu_ports-1:0]             complete_valid,
    input  rob_pkg::robn_t [rob_pkg::fu_ports-1:0]   complete_robn,
    input  logic [rob_pkg::fu_ports-1:0]             complete_taken,
    input  rob_pkg::addr_t [rob_pkg::fu_ports-1:0]   complete_target,
    input  rob_pkg::robn_t                           head,
    output logic [rob_pkg::width-1:0]                head_executed,
    output logic [rob_pkg::width-1:0]                head_success,
    output rob_pkg::arn_t [rob_pkg::width-1:0]       head_dest_arn,
    output rob_pkg::prn_t [rob_pkg::width-1:0]       head_dest_prn,
    output rob_pkg::addr_t [rob_pkg::width-1:0]      head_resolve_target
);

    // per-entry control flags
    logic [rob_pkg::rob_size-1:0] executed;
    logic [rob_pkg::rob_size-1:0] success;

    // per-entry payload
    logic [rob_pkg::rob_size-1:0] is_branch;
    logic [rob_pkg::rob_size-1:0] predict_taken;
    rob_pkg::addr_t               predict_target [rob_pkg::rob_size];
    rob_pkg::addr_t               npc            [rob_pkg::rob_size];
    rob_pkg::addr_t               resolve_target [rob_pkg::rob_size];
    rob_pkg::arn_t                dest_arn       [rob_pkg::rob_size];
    rob_pkg::prn_t                dest_prn       [rob_pkg::rob_size];

    // completion results per port
    rob_pkg::addr_t               comp_target    [rob_pkg::fu_ports];
    logic [rob_pkg::fu_ports-1:0] comp_success;

    // head window slots
    rob_pkg::robn_t               head_slot      [rob_pkg::width];

    // branch check against the stored prediction
    always_comb begin
        for (int j = 0; j < rob_pkg::fu_ports; j++) begin
            comp_target[j]  = complete_taken[j] ? complete_target[j] : npc[complete_robn[j]];
            comp_success[j] = (complete_taken[j] == predict_taken[complete_robn[j]]) &&
                              (comp_target[j] == predict_target[complete_robn[j]]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            executed <= '0;
            success  <= '1;
        end else begin
            for (int i = 0; i < rob_pkg::width; i++) begin
                if (alloc_en[i]) begin
                    executed[alloc_robn[i]] <= 1'b0;  // fresh entry
                    success[alloc_robn[i]]  <= 1'b1;
                end
            end
            // this loop runs later so completion wins on a shared slot
            for (int j = 0; j < rob_pkg::fu_ports; j++) begin
                if (complete_valid[j]) begin
                    executed[complete_robn[j]] <= 1'b1;
                    if (is_branch[complete_robn[j]]) begin
                        success[complete_robn[j]] <= comp_success[j];  // mispredict check
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < rob_pkg::width; i++) begin
            if (alloc_en[i]) begin
                is_branch[alloc_robn[i]]      <= dispatch_is_branch[i];
                predict_taken[alloc_robn[i]]  <= dispatch_predict_taken[i];
                predict_target[alloc_robn[i]] <= dispatch_predict_target[i];
                npc[alloc_robn[i]]            <= dispatch_npc[i];
                dest_arn[alloc_robn[i]]       <= dispatch_dest_arn[i];
                dest_prn[alloc_robn[i]]       <= dispatch_dest_prn[i];
            end
        end
        for (int j = 0; j < rob_pkg::fu_ports; j++) begin
            if (complete_valid[j]) begin
                resolve_target[complete_robn[j]] <= comp_target[j];
            end
        end
    end

    // read head plus 0 and head plus 1 with wrap
    always_comb begin
        for (int i = 0; i < rob_pkg::width; i++) begin
            head_slot[i]           = head + rob_pkg::robn_t'(i);
            head_executed[i]       = executed[head_slot[i]];
            head_success[i]        = success[head_slot[i]];
            head_dest_arn[i]       = dest_arn[head_slot[i]];
            head_dest_prn[i]       = dest_prn[head_slot[i]];
            head_resolve_target[i] = resolve_target[head_slot[i]];
        end
    end

endmodule

// ==== src/rob_ctrl.sv ====
`timescale 1ns/1ns

module rob_ctrl (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [rob_pkg::width-1:0]           dispatch_valid,
    input  logic [rob_pkg::width-1:0]           head_executed,
    input  logic [rob_pkg::width-1:0]           head_success,
    output logic [rob_pkg::width-1:0]           alloc_en,
    output rob_pkg::robn_t [rob_pkg::width-1:0] alloc_robn,
    output rob_pkg::robn_t [rob_pkg::width-1:0] dispatch_robn,
    output rob_pkg::robn_t                      head,
    output logic [rob_pkg::width-1:0]           commit_valid,
    output logic                                squash,
    output logic                                almost_full
);

    rob_pkg::robn_t   tail;
    rob_pkg::rob_cnt_t count;

    rob_pkg::rob_cnt_t n_commit;  // successful commits this cycle
    rob_pkg::rob_cnt_t n_alloc;   // accepted dispatches this cycle
    logic              blocked;   // commit chain stopped
    logic              accept;

    // fewer than alert_depth free slots left
    assign almost_full = count > rob_pkg::rob_cnt_t'(rob_pkg::rob_size - rob_pkg::alert_depth);

    // in-order commit from the head window
    always_comb begin
        commit_valid = '0;
        squash       = 1'b0;
        blocked      = 1'b0;
        n_commit     = '0;
        for (int i = 0; i < rob_pkg::width; i++) begin
            if (!blocked && count > rob_pkg::rob_cnt_t'(i) && head_executed[i]) begin
                commit_valid[i] = 1'b1;
                if (head_success[i]) begin
                    n_commit = n_commit + 1'b1;
                end else begin
                    squash  = 1'b1;  // failed entry retires and the rest is flushed
                    blocked = 1'b1;
                end
            end else begin
                blocked = 1'b1;  // younger ones wait
            end
        end
    end

    // dispatch side
    assign accept = !almost_full && !squash;

    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < rob_pkg::width; i++) begin
            dispatch_robn[i] = tail + rob_pkg::robn_t'(i);
            alloc_robn[i]    = dispatch_robn[i];
            alloc_en[i]      = dispatch_valid[i] && accept;
            n_alloc          = n_alloc + rob_pkg::rob_cnt_t'(alloc_en[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (squash) begin
            head  <= '0;  // buffer empties
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + rob_pkg::robn_t'(n_commit);
            tail  <= tail + rob_pkg::robn_t'(n_alloc);
            count <= count + n_alloc - n_commit;
        end
    end

endmodule

// ==== src/retire_map.sv ====
`timescale 1ns/1ns

module retire_map (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [rob_pkg::width-1:0]           commit_valid,
    input  rob_pkg::arn_t [rob_pkg::width-1:0]  commit_dest_arn,
    input  rob_pkg::prn_t [rob_pkg::width-1:0]  commit_dest_prn,
    input  rob_pkg::arn_t                       map_read_arn,
    output rob_pkg::prn_t                       map_read_prn
);

    // one entry per architectural register
    rob_pkg::prn_t map_q [2**$bits(rob_pkg::arn_t)];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < $size(map_q); r++) begin
                map_q[r] <= rob_pkg::prn_t'(r);  // identity map
            end
        end else begin
            // slot 1 written last so it wins on the same arn
            for (int i = 0; i < rob_pkg::width; i++) begin
                if (commit_valid[i] && commit_dest_arn[i] != '0) begin
                    map_q[commit_dest_arn[i]] <= commit_dest_prn[i];
                end
            end
        end
    end

    assign map_read_prn = map_q[map_read_arn];

endmodule

// ==== src/rob_top.sv ====
`timescale 1ns/1ns

module rob_top (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [rob_pkg::width-1:0]              dispatch_valid,
    input  logic [rob_pkg::width-1:0]              dispatch_is_branch,
    input  logic [rob_pkg::width-1:0]              dispatch_predict_taken,
    input  rob_pkg::addr_t [rob_pkg::width-1:0]    dispatch_predict_target,
    input  rob_pkg::addr_t [rob_pkg::width-1:0]    dispatch_npc,
    input  rob_pkg::arn_t [rob_pkg::width-1:0]     dispatch_dest_arn,
    input  rob_pkg::prn_t [rob_pkg::width-1:0]     dispatch_dest_prn,
    input  logic [rob_pkg::fu_ports-1:0]           complete_valid,
    input  rob_pkg::robn_t [rob_pkg::fu_ports-1:0] complete_robn,
    input  logic [rob_pkg::fu_ports-1:0]           complete_taken,
    input  rob_pkg::addr_t [rob_pkg::fu_ports-1:0] complete_target,
    input  rob_pkg::arn_t                          map_read_arn,
    output rob_pkg::robn_t [rob_pkg::width-1:0]    dispatch_robn,
    output logic                                   almost_full,
    output logic [rob_pkg::width-1:0]              commit_valid,
    output rob_pkg::arn_t [rob_pkg::width-1:0]     commit_dest_arn,
    output rob_pkg::prn_t [rob_pkg::width-1:0]     commit_dest_prn,
    output rob_pkg::addr_t [rob_pkg::width-1:0]    commit_resolve_target,
    output logic                                   squash,
    output rob_pkg::prn_t                          map_read_prn
);

    logic [rob_pkg::width-1:0]           alloc_en;
    rob_pkg::robn_t [rob_pkg::width-1:0] alloc_robn;
    rob_pkg::robn_t                      head;
    logic [rob_pkg::width-1:0]           head_executed;
    logic [rob_pkg::width-1:0]           head_success;

    rob_ctrl i_rob_ctrl (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .head_executed  (head_executed),
        .head_success   (head_success),
        .alloc_en       (alloc_en),
        .alloc_robn     (alloc_robn),
        .dispatch_robn  (dispatch_robn),
        .head           (head),
        .commit_valid   (commit_valid),
        .squash         (squash),
        .almost_full    (almost_full)
    );

    // head window fields go straight out as commit payload
    rob_entry_array i_rob_entry_array (
        .clock                   (clock),
        .reset                   (reset),
        .alloc_en                (alloc_en),
        .alloc_robn              (alloc_robn),
        .dispatch_is_branch      (dispatch_is_branch),
        .dispatch_predict_taken  (dispatch_predict_taken),
        .dispatch_predict_target (dispatch_predict_target),
        .dispatch_npc            (dispatch_npc),
        .dispatch_dest_arn       (dispatch_dest_arn),
        .dispatch_dest_prn       (dispatch_dest_prn),
        .complete_valid          (complete_valid),
        .complete_robn           (complete_robn),
        .complete_taken          (complete_taken),
        .complete_target         (complete_target),
        .head                    (head),
        .head_executed           (head_executed),
        .head_success            (head_success),
        .head_dest_arn           (commit_dest_arn),
        .head_dest_prn           (commit_dest_prn),
        .head_resolve_target     (commit_resolve_target)
    );

    retire_map i_retire_map (
        .clock           (clock),
        .reset           (reset),
        .commit_valid    (commit_valid),
        .commit_dest_arn (commit_dest_arn),
        .commit_dest_prn (commit_dest_prn),
        .map_read_arn    (map_read_arn),
        .map_read_prn    (map_read_prn)
    );

endmodule

// ==== sim/rob_tb.sv ====
`timescale 1ns/1ns

module rob_tb;

    localparam int run_cycles    = 2000;
    localparam int drain_timeout = 400;   // cycles allowed to empty the buffer
    localparam int seed          = 71337;
    localparam int arch_regs     = 32;

    typedef struct packed {
        rob_pkg::robn_t robn;
        logic           is_branch;
        logic           predict_taken;
        rob_pkg::addr_t predict_target;
        rob_pkg::addr_t npc;
        rob_pkg::arn_t  dest_arn;
        rob_pkg::prn_t  dest_prn;
        logic           executed;
        logic           success;
        rob_pkg::addr_t resolve_target;
    } entry_t;

    logic                                   clock;
    logic                                   reset;
    logic [rob_pkg::width-1:0]              dispatch_valid;
    logic [rob_pkg::width-1:0]              dispatch_is_branch;
    logic [rob_pkg::width-1:0]              dispatch_predict_taken;
    rob_pkg::addr_t [rob_pkg::width-1:0]    dispatch_predict_target;
    rob_pkg::addr_t [rob_pkg::width-1:0]    dispatch_npc;
    rob_pkg::arn_t [rob_pkg::width-1:0]     dispatch_dest_arn;
    rob_pkg::prn_t [rob_pkg::width-1:0]     dispatch_dest_prn;
    logic [rob_pkg::fu_ports-1:0]           complete_valid;
    rob_pkg::robn_t [rob_pkg::fu_ports-1:0] complete_robn;
    logic [rob_pkg::fu_ports-1:0]           complete_taken;
    rob_pkg::addr_t [rob_pkg::fu_ports-1:0] complete_target;
    rob_pkg::arn_t                          map_read_arn;
    rob_pkg::robn_t [rob_pkg::width-1:0]    dispatch_robn;
    logic                                   almost_full;
    logic [rob_pkg::width-1:0]              commit_valid;
    rob_pkg::arn_t [rob_pkg::width-1:0]     commit_dest_arn;
    rob_pkg::prn_t [rob_pkg::width-1:0]     commit_dest_prn;
    rob_pkg::addr_t [rob_pkg::width-1:0]    commit_resolve_target;
    logic                                   squash;
    rob_pkg::prn_t                          map_read_prn;

    entry_t         model_q [$];            // live entries with the oldest first
    rob_pkg::prn_t  model_map [arch_regs];
    rob_pkg::robn_t model_tail;
    logic           checking;
    int             errors;

    rob_top i_rob_top (
        .clock                   (clock),
        .reset                   (reset),
        .dispatch_valid          (dispatch_valid),
        .dispatch_is_branch      (dispatch_is_branch),
        .dispatch_predict_taken  (dispatch_predict_taken),
        .dispatch_predict_target (dispatch_predict_target),
        .dispatch_npc            (dispatch_npc),
        .dispatch_dest_arn       (dispatch_dest_arn),
        .dispatch_dest_prn       (dispatch_dest_prn),
        .complete_valid          (complete_valid),
        .complete_robn           (complete_robn),
        .complete_taken          (complete_taken),
        .complete_target         (complete_target),
        .map_read_arn            (map_read_arn),
        .dispatch_robn           (dispatch_robn),
        .almost_full             (almost_full),
        .commit_valid            (commit_valid),
        .commit_dest_arn         (commit_dest_arn),
        .commit_dest_prn         (commit_dest_prn),
        .commit_resolve_target   (commit_resolve_target),
        .squash                  (squash),
        .map_read_prn            (map_read_prn)
    );

    always #20 clock = ~clock;

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    // expected commit group from the model head and whether it squashes
    function automatic int ref_commits(output logic fail);
        int n;
        n    = 0;
        fail = 1'b0;
        for (int i = 0; i < rob_pkg::width; i++) begin
            if (fail || i >= model_q.size() || !model_q[i].executed) begin
                break;
            end
            n++;
            if (!model_q[i].success) begin
                fail = 1'b1;  // failed entry still retires
            end
        end
        return n;
    endfunction

    function automatic rob_pkg::addr_t resolved_target(input entry_t e, input logic taken,
                                                       input rob_pkg::addr_t target);
        return taken ? target : e.npc;
    endfunction

    task automatic compare_outputs();
        logic                      fail;
        int                        n;
        logic [rob_pkg::width-1:0] exp_valid;
        rob_pkg::robn_t            exp_robn;
        n         = ref_commits(fail);
        exp_valid = '0;
        for (int i = 0; i < n; i++) begin
            exp_valid[i] = 1'b1;
        end
        check("commit_valid", exp_valid, commit_valid);
        check("squash", fail, squash);
        check("almost_full", model_q.size() > rob_pkg::rob_size - rob_pkg::alert_depth,
              almost_full);
        for (int i = 0; i < n; i++) begin
            check($sformatf("commit_dest_arn[%0d]", i), model_q[i].dest_arn, commit_dest_arn[i]);
            check($sformatf("commit_dest_prn[%0d]", i), model_q[i].dest_prn, commit_dest_prn[i]);
            check($sformatf("commit_resolve_target[%0d]", i), model_q[i].resolve_target,
                  commit_resolve_target[i]);
        end
        for (int i = 0; i < rob_pkg::width; i++) begin
            exp_robn = model_tail + rob_pkg::robn_t'(i);  // consecutive modulo 16
            check($sformatf("dispatch_robn[%0d]", i), exp_robn, dispatch_robn[i]);
        end
        check("map_read_prn", model_map[map_read_arn], map_read_prn);
        if (map_read_arn == '0) begin
            check("map_reg_zero", 0, map_read_prn);
        end
    endtask

    // advance the model by the inputs that the next edge takes in
    task automatic update_model();
        logic   fail;
        logic   full;
        int     n;
        entry_t e;
        n    = ref_commits(fail);
        full = model_q.size() > rob_pkg::rob_size - rob_pkg::alert_depth;
        for (int j = 0; j < rob_pkg::fu_ports; j++) begin
            for (int k = 0; k < model_q.size(); k++) begin
                if (complete_valid[j] && model_q[k].robn == complete_robn[j]) begin
                    model_q[k].executed       = 1'b1;
                    model_q[k].resolve_target = resolved_target(model_q[k], complete_taken[j],
                                                                complete_target[j]);
                    if (model_q[k].is_branch) begin
                        model_q[k].success = (complete_taken[j] == model_q[k].predict_taken) &&
                            (model_q[k].resolve_target == model_q[k].predict_target);
                    end
                end
            end
        end
        for (int i = 0; i < n; i++) begin
            e = model_q.pop_front();
            if (e.dest_arn != '0) begin
                model_map[e.dest_arn] = e.dest_prn;  // slot 1 lands last
            end
        end
        if (fail) begin
            model_q.delete();  // squash drops younger entries and the offered dispatch
            model_tail = '0;
        end else if (!full) begin
            for (int i = 0; i < rob_pkg::width; i++) begin
                if (dispatch_valid[i]) begin
                    e.robn           = model_tail;
                    e.is_branch      = dispatch_is_branch[i];
                    e.predict_taken  = dispatch_predict_taken[i];
                    e.predict_target = dispatch_predict_target[i];
                    e.npc            = dispatch_npc[i];
                    e.dest_arn       = dispatch_dest_arn[i];
                    e.dest_prn       = dispatch_dest_prn[i];
                    e.executed       = 1'b0;
                    e.success        = 1'b1;
                    e.resolve_target = '0;
                    model_q.push_back(e);
                    model_tail = model_tail + rob_pkg::robn_t'(1);
                end
            end
        end
    endtask

    task automatic drive_cycle(input logic allow_dispatch, input logic slow);
        logic   fail;
        int     n_disp;
        int     n_comp;
        int     pick;
        int     cand [$];
        entry_t e;
        void'(ref_commits(fail));
        dispatch_valid          = '0;
        dispatch_is_branch      = '0;
        dispatch_predict_taken  = '0;
        dispatch_predict_target = '0;
        dispatch_npc            = '0;
        dispatch_dest_arn       = '0;
        dispatch_dest_prn       = '0;
        complete_valid          = '0;
        complete_robn           = '0;
        complete_taken          = '0;
        complete_target         = '0;
        // a squash cycle still gets an offer that the DUT must drop
        if (allow_dispatch && !almost_full) begin
            n_disp = int'($urandom % 3);
            for (int i = 0; i < n_disp; i++) begin
                dispatch_valid[i]          = 1'b1;
                dispatch_is_branch[i]      = ($urandom % 3) == 0;
                dispatch_predict_taken[i]  = dispatch_is_branch[i] && ($urandom % 2) == 1;
                dispatch_npc[i]            = $urandom & 32'hffff_fffc;
                dispatch_predict_target[i] = dispatch_predict_taken[i] ?
                                             ($urandom & 32'hffff_fffc) : dispatch_npc[i];
                dispatch_dest_arn[i]       = rob_pkg::arn_t'($urandom % arch_regs);
                dispatch_dest_prn[i]       = rob_pkg::prn_t'($urandom % 64);
            end
        end
        if (!fail) begin  // no completion in a squash cycle
            if (slow) begin
                n_comp = ($urandom % 4 == 0) ? 1 : 0;  // lets the buffer fill up
            end else begin
                n_comp = int'($urandom % 4);
            end
            for (int k = 0; k < model_q.size(); k++) begin
                if (!model_q[k].executed) begin
                    cand.push_back(k);
                end
            end
            for (int j = 0; j < n_comp && cand.size() > 0; j++) begin
                pick = int'($urandom % cand.size());
                e    = model_q[cand[pick]];
                cand.delete(pick);
                complete_valid[j]  = 1'b1;
                complete_robn[j]   = e.robn;
                complete_target[j] = $urandom & 32'hffff_fffc;
                if (e.is_branch && $urandom % 16 != 0) begin
                    complete_taken[j] = e.predict_taken;  // resolves as predicted
                    if (e.predict_taken) begin
                        complete_target[j] = e.predict_target;
                    end
                end else if (e.is_branch) begin
                    if (e.predict_taken && $urandom % 2 == 0) begin
                        complete_taken[j] = 1'b1;  // taken to a wrong target
                    end else begin
                        complete_taken[j] = !e.predict_taken;  // wrong direction
                    end
                end
            end
        end
        map_read_arn = rob_pkg::arn_t'($urandom % arch_regs);
    endtask

    always @(negedge clock) begin
        if (checking) begin
            compare_outputs();
            update_model();
        end
    end

    initial begin
        int waited;
        void'($urandom(seed));
        clock    = 1'b0;
        reset    = 1'b1;
        checking = 1'b0;
        errors   = 0;
        drive_cycle(1'b0, 1'b0);
        map_read_arn = '0;
        model_tail   = '0;
        for (int r = 0; r < arch_regs; r++) begin
            model_map[r] = rob_pkg::prn_t'(r);
        end
        repeat (4) @(posedge clock);
        #2;
        reset    = 1'b0;
        checking = 1'b1;
        for (int cycle = 0; cycle < run_cycles; cycle++) begin
            @(posedge clock);
            #2;
            drive_cycle(1'b1, ((cycle / 150) % 3) == 1);
        end
        waited = 0;
        do begin
            @(posedge clock);
            #2;
            drive_cycle(1'b0, 1'b0);
            waited++;
        end while (model_q.size() != 0 && waited < drain_timeout);
        if (model_q.size() != 0) begin
            $display("Timeout: the reorder buffer did not drain in %0d cycles", drain_timeout);
            $display("Some tests failed");
            $fatal(1, "drain did not finish");
        end
        for (int r = 0; r < arch_regs; r++) begin  // sweep of the retirement map
            @(posedge clock);
            #2;
            drive_cycle(1'b0, 1'b0);
            map_read_arn = rob_pkg::arn_t'(r);
        end
        @(negedge clock);
        #1;
        if (errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== tb.f ====
src/rob_pkg.sv
src/rob_entry_array.sv
src/rob_ctrl.sv
src/retire_map.sv
src/rob_top.sv
sim/rob_tb.sv

// ==== Makefile ====
# Verilator build and run for the reorder buffer testbench

VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All tests passed
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BINARY) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
